// ==== logic/harness_consts.svh ====
// Harness constants
// Bus widths, memory depths and the debug hold-off count shared by
// the packages, the RTL and the testbench

`ifndef HARNESS_CONSTS_SVH
`define HARNESS_CONSTS_SVH

// Shared bus
`define ADDR_WIDTH 32
`define DATA_WIDTH 64
`define BE_WIDTH   8

// Memories, depth in 64-bit words
`define SRAM_WORDS 1024
`define ROM_WORDS  8

// Cycles after power-on reset before debug requests reach the core
`define DEBUG_HOLDOFF_CYCLES 50

`endif

// ==== logic/bus_pkg.sv ====
// Shared bus types
// Request and response of the request/grant bus between the masters,
// the arbiter, the decoder and the targets

`default_nettype none

`include "harness_consts.svh"

package bus_pkg;

  // Held stable by the master until it sees its grant
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`BE_WIDTH-1:0]   be;
    logic [`DATA_WIDTH-1:0] wdata;
  } bus_req_t;

  // Returned one cycle after the grant, never stalled
  typedef struct packed {
    logic                   valid;
    logic                   err;
    logic [`DATA_WIDTH-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== logic/soc_map_pkg.sv ====
// SoC address map
// Target indices, base addresses, CLINT register offsets and the
// contents of the boot ROM

`default_nettype none

`include "harness_consts.svh"

package soc_map_pkg;

  typedef enum logic [1:0] {
    TGT_ROM   = 2'd0,
    TGT_SRAM  = 2'd1,
    TGT_CLINT = 2'd2,
    TGT_NONE  = 2'd3
  } target_e;

  // ------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------
  localparam logic [`ADDR_WIDTH-1:0] ROM_BASE     = 32'h0001_0000;
  localparam logic [`ADDR_WIDTH-1:0] ROM_LENGTH   = 32'h0001_0000;
  localparam logic [`ADDR_WIDTH-1:0] CLINT_BASE   = 32'h0200_0000;
  localparam logic [`ADDR_WIDTH-1:0] CLINT_LENGTH = 32'h000C_0000;
  localparam logic [`ADDR_WIDTH-1:0] SRAM_BASE    = 32'h8000_0000;
  localparam logic [`ADDR_WIDTH-1:0] SRAM_LENGTH  = `ADDR_WIDTH'(`SRAM_WORDS * 8);

  // CLINT registers, relative to CLINT_BASE
  localparam logic [`ADDR_WIDTH-1:0] MSIP_OFFSET     = 32'h0000_0000;
  localparam logic [`ADDR_WIDTH-1:0] MTIMECMP_OFFSET = 32'h0000_4000;
  localparam logic [`ADDR_WIDTH-1:0] MTIME_OFFSET    = 32'h0000_BFF8;

  // ------------------------------------------------------------
  // Boot code, word 0 first at the bottom
  // ------------------------------------------------------------
  localparam logic [`ROM_WORDS-1:0][`DATA_WIDTH-1:0] BOOT_CODE = {
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_0000,
    64'h1050_0073_0000_0013,
    64'h0002_8067_0200_0593,
    64'h0000_0013_0102_829b,
    64'hf140_2573_0010_029b,
    64'h0000_0297_3040_5073,
    64'h3000_5073_0010_0413
  };

endpackage

`default_nettype wire

// ==== logic/reset_debug_ctrl.sv ====
// Reset and debug glue
// Peripheral reset from power-on reset or ndmreset with synchronized
// release, and a hold-off window for debug requests after power-on

`default_nettype none

`include "harness_consts.svh"

module reset_debug_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  output logic periph_rst_no,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = $clog2(`DEBUG_HOLDOFF_CYCLES + 1);

  logic                rst_comb_n;
  logic [1:0]          rst_sync_q;
  logic [CntWidth-1:0] holdoff_q;

  // ------------------------------------------------------------
  // Peripheral reset, asserted at once, released after two flops
  // ------------------------------------------------------------
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign periph_rst_no = rst_sync_q[1];

  // ------------------------------------------------------------
  // Debug request hold-off
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holdoff_q <= CntWidth'(`DEBUG_HOLDOFF_CYCLES);
    end else if (holdoff_q != '0) begin
      holdoff_q <= holdoff_q - 1'b1;
    end
  end

  assign debug_req_o = (holdoff_q == '0) & debug_req_i;

  a_holdoff : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (holdoff_q != '0) |-> !debug_req_o);

endmodule

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
// Bus arbiter
// Round-robin grant between the core and debug masters, the response
// goes back only to the master that was granted the cycle before

`default_nettype none

module bus_arbiter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  bus_pkg::bus_req_t core_req_i,
  input  bus_pkg::bus_req_t dbg_req_i,
  input  bus_pkg::bus_rsp_t bus_rsp_i,
  output logic              core_gnt_o,
  output logic              dbg_gnt_o,
  output bus_pkg::bus_req_t bus_req_o,
  output bus_pkg::bus_rsp_t core_rsp_o,
  output bus_pkg::bus_rsp_t dbg_rsp_o
);

  // Last granted master, also owner of the pending response
  logic last_dbg_q;

  // Debug counts as last winner after reset so the core wins first
  assign core_gnt_o = core_req_i.req & (~dbg_req_i.req | last_dbg_q);
  assign dbg_gnt_o  = dbg_req_i.req & (~core_req_i.req | ~last_dbg_q);

  assign bus_req_o = dbg_gnt_o ? dbg_req_i : core_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_dbg_q <= 1'b1;
    end else if (core_gnt_o || dbg_gnt_o) begin
      last_dbg_q <= dbg_gnt_o;
    end
  end

  // Steer response to its owner
  assign core_rsp_o = last_dbg_q ? '0 : bus_rsp_i;
  assign dbg_rsp_o  = last_dbg_q ? bus_rsp_i : '0;

  a_one_grant : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core_gnt_o && dbg_gnt_o));

  // Fixed one-cycle response through decoder and targets
  a_core_rsp : assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_gnt_o |=> core_rsp_o.valid);
  a_dbg_rsp : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_gnt_o |=> dbg_rsp_o.valid);

endmodule

`default_nettype wire

// ==== logic/bus_decoder.sv ====
// Address decoder
// Routes the granted access to ROM, SRAM or CLINT with a target-relative
// address and builds the response one cycle later

`default_nettype none

`include "harness_consts.svh"

module bus_decoder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  bus_pkg::bus_req_t      bus_req_i,
  output logic                   rom_req_o,
  output logic                   sram_req_o,
  output logic                   clint_req_o,
  output logic                   we_o,
  output logic [`ADDR_WIDTH-1:0] addr_o,
  output logic [`BE_WIDTH-1:0]   be_o,
  output logic [`DATA_WIDTH-1:0] wdata_o,
  input  logic [`DATA_WIDTH-1:0] rom_rdata_i,
  input  logic [`DATA_WIDTH-1:0] sram_rdata_i,
  input  logic [`DATA_WIDTH-1:0] clint_rdata_i,
  output bus_pkg::bus_rsp_t      bus_rsp_o
);

  logic [`ADDR_WIDTH-1:0] rom_off;
  logic [`ADDR_WIDTH-1:0] sram_off;
  logic [`ADDR_WIDTH-1:0] clint_off;
  soc_map_pkg::target_e   tgt;
  soc_map_pkg::target_e   tgt_q;
  logic                   valid_q;
  logic                   we_q;
  logic [`DATA_WIDTH-1:0] rdata;

  // ------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------
  assign rom_off   = bus_req_i.addr - soc_map_pkg::ROM_BASE;
  assign sram_off  = bus_req_i.addr - soc_map_pkg::SRAM_BASE;
  assign clint_off = bus_req_i.addr - soc_map_pkg::CLINT_BASE;

  always_comb begin
    tgt    = soc_map_pkg::TGT_NONE;
    addr_o = '0;
    if (rom_off < soc_map_pkg::ROM_LENGTH) begin
      tgt    = soc_map_pkg::TGT_ROM;
      addr_o = rom_off;
    end else if (sram_off < soc_map_pkg::SRAM_LENGTH) begin
      tgt    = soc_map_pkg::TGT_SRAM;
      addr_o = sram_off;
    end else if (clint_off < soc_map_pkg::CLINT_LENGTH) begin
      tgt    = soc_map_pkg::TGT_CLINT;
      addr_o = clint_off;
    end
  end

  assign rom_req_o   = bus_req_i.req && (tgt == soc_map_pkg::TGT_ROM);
  assign sram_req_o  = bus_req_i.req && (tgt == soc_map_pkg::TGT_SRAM);
  assign clint_req_o = bus_req_i.req && (tgt == soc_map_pkg::TGT_CLINT);
  assign we_o        = bus_req_i.we;
  assign be_o        = bus_req_i.be;
  assign wdata_o     = bus_req_i.wdata;

  // ------------------------------------------------------------
  // Response side
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
      tgt_q   <= soc_map_pkg::TGT_NONE;
    end else begin
      valid_q <= bus_req_i.req;
      if (bus_req_i.req) begin
        we_q  <= bus_req_i.we;
        tgt_q <= tgt;
      end
    end
  end

  always_comb begin
    case (tgt_q)
      soc_map_pkg::TGT_ROM:   rdata = rom_rdata_i;
      soc_map_pkg::TGT_SRAM:  rdata = sram_rdata_i;
      soc_map_pkg::TGT_CLINT: rdata = clint_rdata_i;
      default:                rdata = '0;
    endcase
  end

  // Writes and errors return zero data
  assign bus_rsp_o.valid = valid_q;
  assign bus_rsp_o.err   = valid_q && (tgt_q == soc_map_pkg::TGT_NONE);
  assign bus_rsp_o.rdata = (valid_q && !we_q) ? rdata : '0;

  a_one_target : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rom_req_o, sram_req_o, clint_req_o}));

endmodule

`default_nettype wire

// ==== logic/boot_rom.sv ====
// Boot ROM
// Fixed boot code table, one registered 64-bit word per request

`default_nettype none

`include "harness_consts.svh"

module boot_rom (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  output logic [`DATA_WIDTH-1:0] rdata_o
);

  localparam int unsigned IdxWidth = $clog2(`ROM_WORDS);

  logic [`ADDR_WIDTH-4:0] word_idx;

  assign word_idx = addr_i[`ADDR_WIDTH-1:3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      // Past the end of the table
      rdata_o <= (word_idx < `ROM_WORDS) ? soc_map_pkg::BOOT_CODE[word_idx[IdxWidth-1:0]] : '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sram.sv ====
// SRAM
// Word-addressed 64-bit memory with byte enables and registered read

`default_nettype none

`include "harness_consts.svh"

module sram (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  input  logic [`BE_WIDTH-1:0]   be_i,
  input  logic [`DATA_WIDTH-1:0] wdata_i,
  output logic [`DATA_WIDTH-1:0] rdata_o
);

  localparam int unsigned IdxWidth = $clog2(`SRAM_WORDS);

  logic [`DATA_WIDTH-1:0] mem_q [`SRAM_WORDS];
  logic [IdxWidth-1:0]    word_idx;

  assign word_idx = addr_i[3 +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned i = 0; i < `BE_WIDTH; i++) begin
        if (be_i[i]) begin
          mem_q[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[word_idx];
    end
  end

endmodule

`default_nettype wire

// ==== logic/clint.sv ====
// Core-local interruptor
// Machine timer counting rtc edges, timer compare and software
// interrupt registers for a single hart

`default_nettype none

`include "harness_consts.svh"

module clint (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rtc_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  input  logic [`BE_WIDTH-1:0]   be_i,
  input  logic [`DATA_WIDTH-1:0] wdata_i,
  output logic [`DATA_WIDTH-1:0] rdata_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  logic                   rtc_q;
  logic                   tick;
  logic [`DATA_WIDTH-1:0] mtime_q;
  logic [`DATA_WIDTH-1:0] mtimecmp_q;
  logic                   msip_q;
  logic                   sel_msip;
  logic                   sel_cmp;
  logic                   sel_time;

  function automatic logic [`DATA_WIDTH-1:0] merge_bytes(
    input logic [`DATA_WIDTH-1:0] old_val,
    input logic [`DATA_WIDTH-1:0] new_val,
    input logic [`BE_WIDTH-1:0]   be
  );
    logic [`DATA_WIDTH-1:0] res;
    res = old_val;
    for (int unsigned i = 0; i < `BE_WIDTH; i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  assign sel_msip = addr_i[`ADDR_WIDTH-1:3] == soc_map_pkg::MSIP_OFFSET[`ADDR_WIDTH-1:3];
  assign sel_cmp  = addr_i[`ADDR_WIDTH-1:3] == soc_map_pkg::MTIMECMP_OFFSET[`ADDR_WIDTH-1:3];
  assign sel_time = addr_i[`ADDR_WIDTH-1:3] == soc_map_pkg::MTIME_OFFSET[`ADDR_WIDTH-1:3];

  // Rising edge of the real-time clock
  assign tick = rtc_i & ~rtc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q      <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      rdata_o    <= '0;
    end else begin
      rtc_q <= rtc_i;
      // A write to mtime takes priority over the tick
      if (req_i && we_i && sel_time) begin
        mtime_q <= merge_bytes(mtime_q, wdata_i, be_i);
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (req_i && we_i && sel_cmp) mtimecmp_q <= merge_bytes(mtimecmp_q, wdata_i, be_i);
      if (req_i && we_i && sel_msip && be_i[0]) msip_q <= wdata_i[0];
      if (req_i && !we_i) begin
        rdata_o <= sel_time ? mtime_q :
                   sel_cmp  ? mtimecmp_q :
                   sel_msip ? `DATA_WIDTH'(msip_q) : '0;
      end
    end
  end

  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// ==== logic/harness_top.sv ====
// Memory side of the test harness
// Core and debug masters share one bus through a round-robin arbiter,
// a decoder routes accesses to boot ROM, SRAM and CLINT

`default_nettype none

`include "harness_consts.svh"

module harness_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  logic              ndmreset_i,
  input  logic              debug_req_i,
  input  bus_pkg::bus_req_t core_req_i,
  input  bus_pkg::bus_req_t dbg_req_i,
  output logic              core_gnt_o,
  output logic              dbg_gnt_o,
  output bus_pkg::bus_rsp_t core_rsp_o,
  output bus_pkg::bus_rsp_t dbg_rsp_o,
  output logic              debug_req_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  logic periph_rst_n;

  bus_pkg::bus_req_t bus_req;
  bus_pkg::bus_rsp_t bus_rsp;

  // Target side of the decoder
  logic                   rom_req;
  logic                   sram_req;
  logic                   clint_req;
  logic                   tgt_we;
  logic [`ADDR_WIDTH-1:0] tgt_addr;
  logic [`BE_WIDTH-1:0]   tgt_be;
  logic [`DATA_WIDTH-1:0] tgt_wdata;
  logic [`DATA_WIDTH-1:0] rom_rdata;
  logic [`DATA_WIDTH-1:0] sram_rdata;
  logic [`DATA_WIDTH-1:0] clint_rdata;

  reset_debug_ctrl i_reset_debug_ctrl (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .ndmreset_i    ( ndmreset_i   ),
    .debug_req_i   ( debug_req_i  ),
    .periph_rst_no ( periph_rst_n ),
    .debug_req_o   ( debug_req_o  )
  );

  bus_arbiter i_bus_arbiter (
    .clk_i      ( clk_i        ),
    .rst_ni     ( periph_rst_n ),
    .core_req_i ( core_req_i   ),
    .dbg_req_i  ( dbg_req_i    ),
    .bus_rsp_i  ( bus_rsp      ),
    .core_gnt_o ( core_gnt_o   ),
    .dbg_gnt_o  ( dbg_gnt_o    ),
    .bus_req_o  ( bus_req      ),
    .core_rsp_o ( core_rsp_o   ),
    .dbg_rsp_o  ( dbg_rsp_o    )
  );

  bus_decoder i_bus_decoder (
    .clk_i         ( clk_i        ),
    .rst_ni        ( periph_rst_n ),
    .bus_req_i     ( bus_req      ),
    .rom_req_o     ( rom_req      ),
    .sram_req_o    ( sram_req     ),
    .clint_req_o   ( clint_req    ),
    .we_o          ( tgt_we       ),
    .addr_o        ( tgt_addr     ),
    .be_o          ( tgt_be       ),
    .wdata_o       ( tgt_wdata    ),
    .rom_rdata_i   ( rom_rdata    ),
    .sram_rdata_i  ( sram_rdata   ),
    .clint_rdata_i ( clint_rdata  ),
    .bus_rsp_o     ( bus_rsp      )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i        ),
    .rst_ni  ( periph_rst_n ),
    .req_i   ( rom_req      ),
    .addr_i  ( tgt_addr     ),
    .rdata_o ( rom_rdata    )
  );

  // Power-on reset only, contents survive ndmreset
  sram i_sram (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( sram_req   ),
    .we_i    ( tgt_we     ),
    .addr_i  ( tgt_addr   ),
    .be_i    ( tgt_be     ),
    .wdata_i ( tgt_wdata  ),
    .rdata_o ( sram_rdata )
  );

  clint i_clint (
    .clk_i       ( clk_i        ),
    .rst_ni      ( periph_rst_n ),
    .rtc_i       ( rtc_i        ),
    .req_i       ( clint_req    ),
    .we_i        ( tgt_we       ),
    .addr_i      ( tgt_addr     ),
    .be_i        ( tgt_be       ),
    .wdata_i     ( tgt_wdata    ),
    .rdata_o     ( clint_rdata  ),
    .timer_irq_o ( timer_irq_o  ),
    .ipi_o       ( ipi_o        )
  );

endmodule

`default_nettype wire

// ==== verification/tb_harness.sv ====
// Harness testbench
// Plays the core, the debug master and the debug module, and runs
// directed tests over the shared bus, the CLINT and the reset glue

`default_nettype none

`include "harness_consts.svh"

module tb_harness;

  timeunit 1ns;
  timeprecision 100ps;

  // All tests together take a few hundred cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int NUM_SRAM_WORDS = 4;

  logic              clk;
  logic              rst_n;
  logic              rtc;
  logic              ndmreset;
  logic              debug_req;
  bus_pkg::bus_req_t core_req;
  bus_pkg::bus_req_t dbg_req;
  logic              core_gnt;
  logic              dbg_gnt;
  bus_pkg::bus_rsp_t core_rsp;
  bus_pkg::bus_rsp_t dbg_rsp;
  logic              debug_req_out;
  logic              timer_irq;
  logic              ipi;

  int          cycle_cnt = 0;
  logic [31:0] lfsr_state;

  // Expected SRAM contents, shared by the SRAM, arbitration and reset tests
  logic [`ADDR_WIDTH-1:0] sram_addr [NUM_SRAM_WORDS];
  logic [`DATA_WIDTH-1:0] sram_exp  [NUM_SRAM_WORDS];

  harness_top harness_top_i (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .rtc_i       ( rtc           ),
    .ndmreset_i  ( ndmreset      ),
    .debug_req_i ( debug_req     ),
    .core_req_i  ( core_req      ),
    .dbg_req_i   ( dbg_req       ),
    .core_gnt_o  ( core_gnt      ),
    .dbg_gnt_o   ( dbg_gnt       ),
    .core_rsp_o  ( core_rsp      ),
    .dbg_rsp_o   ( dbg_rsp       ),
    .debug_req_o ( debug_req_out ),
    .timer_irq_o ( timer_irq     ),
    .ipi_o       ( ipi           )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_equal(input string test_name, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s, %s: expected 0x%h, actual 0x%h",
               test_name, what, expected, actual);
      abort_run();
    end
  endtask

  // Right-shift Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) nxt = nxt ^ 32'h8020_0003;
    return nxt;
  endfunction

  task automatic rand_bits(input int nbits, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      val[i]     = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [63:0] apply_byte_enables(input logic [63:0] old_val,
                                                     input logic [63:0] new_val,
                                                     input logic [7:0]  be);
    logic [63:0] res;
    res = old_val;
    for (int i = 0; i < 8; i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  function automatic bus_pkg::bus_req_t make_req(input logic we, input logic [31:0] addr,
                                                 input logic [7:0] be, input logic [63:0] wdata);
    bus_pkg::bus_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.be    = be;
    r.wdata = wdata;
    return r;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Holds the request until granted, returns the response of the next cycle
  task automatic bus_access(input string test_name, input logic use_dbg,
                            input bus_pkg::bus_req_t r, output bus_pkg::bus_rsp_t rsp);
    next_cycle();
    if (use_dbg) dbg_req = r;
    else core_req = r;
    @(negedge clk);
    while (!(use_dbg ? dbg_gnt : core_gnt)) begin
      @(negedge clk);
    end
    next_cycle();
    if (use_dbg) dbg_req = '0;
    else core_req = '0;
    @(negedge clk);
    rsp = use_dbg ? dbg_rsp : core_rsp;
    check_equal(test_name, "response valid", 64'd1, 64'(rsp.valid));
  endtask

  task automatic read_word(input string test_name, input logic use_dbg,
                           input logic [31:0] addr, output logic [63:0] rdata);
    bus_pkg::bus_rsp_t rsp;
    bus_access(test_name, use_dbg, make_req(1'b0, addr, 8'hff, 64'd0), rsp);
    check_equal(test_name, "read err", 64'd0, 64'(rsp.err));
    rdata = rsp.rdata;
  endtask

  task automatic write_word(input string test_name, input logic use_dbg,
                            input logic [31:0] addr, input logic [7:0] be,
                            input logic [63:0] wdata);
    bus_pkg::bus_rsp_t rsp;
    bus_access(test_name, use_dbg, make_req(1'b1, addr, be, wdata), rsp);
    check_equal(test_name, "write err", 64'd0, 64'(rsp.err));
    check_equal(test_name, "write rdata", 64'd0, rsp.rdata);
  endtask

  task automatic rtc_pulse();
    next_cycle();
    rtc = 1'b1;
    next_cycle();
    rtc = 1'b0;
    @(negedge clk);
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic apply_reset();
    rst_n     = 1'b0;
    debug_req = 1'b1;
    repeat (10) next_cycle();
    check_equal("reset", "core gnt", 64'd0, 64'(core_gnt));
    check_equal("reset", "dbg gnt", 64'd0, 64'(dbg_gnt));
    check_equal("reset", "core valid", 64'd0, 64'(core_rsp.valid));
    check_equal("reset", "dbg valid", 64'd0, 64'(dbg_rsp.valid));
    check_equal("reset", "timer irq", 64'd0, 64'(timer_irq));
    check_equal("reset", "ipi", 64'd0, 64'(ipi));
    check_equal("reset", "debug req", 64'd0, 64'(debug_req_out));
  endtask

  task automatic test_debug_holdoff();
    debug_req = 1'b1;
    rst_n     = 1'b1;
    for (int i = 0; i < `DEBUG_HOLDOFF_CYCLES; i++) begin
      @(negedge clk);
      check_equal("debug_holdoff", "debug req blocked", 64'd0, 64'(debug_req_out));
    end
    @(negedge clk);
    check_equal("debug_holdoff", "debug req passed", 64'd1, 64'(debug_req_out));
    next_cycle();
    debug_req = 1'b0;
  endtask

  task automatic test_boot_rom();
    logic [63:0] data;
    for (int i = 0; i < `ROM_WORDS; i++) begin
      read_word("boot_rom", 1'b0, soc_map_pkg::ROM_BASE + 32'(8 * i), data);
      check_equal("boot_rom", "boot word", soc_map_pkg::BOOT_CODE[i], data);
    end
    // Inside the ROM window but past the table
    read_word("boot_rom", 1'b0, soc_map_pkg::ROM_BASE + 32'(8 * `ROM_WORDS), data);
    check_equal("boot_rom", "past table", 64'd0, data);
  endtask

  task automatic test_sram_bytes();
    logic [63:0] full;
    logic [63:0] part;
    logic [63:0] be_bits;
    logic [63:0] data;
    sram_addr[0] = soc_map_pkg::SRAM_BASE + 32'h0000_0018;
    sram_addr[1] = soc_map_pkg::SRAM_BASE + 32'h0000_0088;
    sram_addr[2] = soc_map_pkg::SRAM_BASE + 32'h0000_0800;
    sram_addr[3] = soc_map_pkg::SRAM_BASE + 32'(8 * (`SRAM_WORDS - 1));
    for (int i = 0; i < NUM_SRAM_WORDS; i++) begin
      rand_bits(64, full);
      rand_bits(64, part);
      rand_bits(8, be_bits);
      write_word("sram_bytes", 1'b1, sram_addr[i], 8'hff, full);
      write_word("sram_bytes", 1'b1, sram_addr[i], be_bits[7:0], part);
      sram_exp[i] = apply_byte_enables(full, part, be_bits[7:0]);
    end
    for (int i = 0; i < NUM_SRAM_WORDS; i++) begin
      read_word("sram_bytes", 1'b0, sram_addr[i], data);
      check_equal("sram_bytes", "merged word", sram_exp[i], data);
    end
  endtask

  task automatic test_arbitration();
    logic [63:0] data;
    // A debug access first, so the core wins the conflict
    read_word("arbitration", 1'b1, sram_addr[0], data);
    check_equal("arbitration", "debug warmup", sram_exp[0], data);
    next_cycle();
    core_req = make_req(1'b0, sram_addr[1], 8'hff, 64'd0);
    dbg_req  = make_req(1'b0, sram_addr[2], 8'hff, 64'd0);
    @(negedge clk);
    check_equal("arbitration", "core gnt first", 64'd1, 64'(core_gnt));
    check_equal("arbitration", "dbg waits", 64'd0, 64'(dbg_gnt));
    next_cycle();
    core_req = '0;
    @(negedge clk);
    check_equal("arbitration", "core valid", 64'd1, 64'(core_rsp.valid));
    check_equal("arbitration", "core data", sram_exp[1], core_rsp.rdata);
    check_equal("arbitration", "dbg gnt second", 64'd1, 64'(dbg_gnt));
    check_equal("arbitration", "no dbg valid", 64'd0, 64'(dbg_rsp.valid));
    next_cycle();
    dbg_req = '0;
    @(negedge clk);
    check_equal("arbitration", "dbg valid", 64'd1, 64'(dbg_rsp.valid));
    check_equal("arbitration", "dbg data", sram_exp[2], dbg_rsp.rdata);
    check_equal("arbitration", "no core valid", 64'd0, 64'(core_rsp.valid));
  endtask

  task automatic test_clint();
    logic [63:0] data;
    write_word("clint", 1'b0, soc_map_pkg::CLINT_BASE + soc_map_pkg::MTIMECMP_OFFSET,
               8'hff, 64'd3);
    for (int i = 1; i <= 3; i++) begin
      rtc_pulse();
      check_equal("clint", "timer irq", (i >= 3) ? 64'd1 : 64'd0, 64'(timer_irq));
    end
    write_word("clint", 1'b0, soc_map_pkg::CLINT_BASE + soc_map_pkg::MSIP_OFFSET,
               8'hff, 64'd1);
    check_equal("clint", "ipi", 64'd1, 64'(ipi));
    read_word("clint", 1'b0, soc_map_pkg::CLINT_BASE + soc_map_pkg::MTIME_OFFSET, data);
    check_equal("clint", "mtime", 64'd3, data);
  endtask

  task automatic test_reset_errors();
    bus_pkg::bus_rsp_t rsp;
    logic [63:0]       data;
    bus_access("reset_errors", 1'b0, make_req(1'b0, 32'h4000_0000, 8'hff, 64'd0), rsp);
    check_equal("reset_errors", "unmapped err", 64'd1, 64'(rsp.err));
    check_equal("reset_errors", "unmapped rdata", 64'd0, rsp.rdata);
    next_cycle();
    ndmreset = 1'b1;
    @(negedge clk);
    check_equal("reset_errors", "ipi in ndmreset", 64'd0, 64'(ipi));
    check_equal("reset_errors", "timer irq in ndmreset", 64'd0, 64'(timer_irq));
    next_cycle();
    ndmreset = 1'b0;
    // Peripheral reset releases two cycles after ndmreset
    repeat (3) next_cycle();
    @(negedge clk);
    check_equal("reset_errors", "ipi after ndmreset", 64'd0, 64'(ipi));
    check_equal("reset_errors", "timer irq after ndmreset", 64'd0, 64'(timer_irq));
    for (int i = 0; i < NUM_SRAM_WORDS; i++) begin
      read_word("reset_errors", 1'b0, sram_addr[i], data);
      check_equal("reset_errors", "sram kept", sram_exp[i], data);
    end
  endtask

  // ------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------
  initial begin
    rst_n      = 1'b0;
    rtc        = 1'b0;
    ndmreset   = 1'b0;
    debug_req  = 1'b0;
    core_req   = '0;
    dbg_req    = '0;
    lfsr_state = 32'h3afc_ffc5;

    apply_reset();
    test_debug_holdoff();
    test_boot_rom();
    test_sram_bytes();
    test_arbitration();
    test_clint();
    test_reset_errors();

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/bus_pkg.sv
logic/soc_map_pkg.sv
logic/reset_debug_ctrl.sv
logic/bus_arbiter.sv
logic/bus_decoder.sv
logic/boot_rom.sv
logic/sram.sv
logic/clint.sv
logic/harness_top.sv
verification/tb_harness.sv
